// File: include/tcm_arbiter_params.svh
// Width and region-nibble macros for the TCM crossbar arbiter
`ifndef TCM_ARBITER_PARAMS_SVH
`define TCM_ARBITER_PARAMS_SVH

// Slave side address width, low bits of the master address
`define TCM_ADDR_WIDTH 12

// Data bus width shared by both masters and all slaves
`define TCM_DATA_WIDTH 32

// One byte select per data byte
`define TCM_STRB_WIDTH 4

// Region nibble sits at the top of the 32-bit master address
`define TCM_REGION_LSB 28

// Region nibble encodings
`define TCM_REGION_CODE   4'h0
`define TCM_REGION_DATA   4'h2
`define TCM_REGION_PERIPH 4'hF

`endif

// File: hw/tcm_arbiter_pkg.sv
// Package with slave and owner enums and the master and slave bus structs
`include "tcm_arbiter_params.svh"

package tcm_arbiter_pkg;

   // Decoded target, also used as registered return source
   typedef enum logic [1:0] {
      slave_code   = 2'd0,
      slave_data   = 2'd1,
      slave_periph = 2'd2
   } tcm_slave_e;

   // Which master drives one slave in the current cycle
   typedef enum logic [1:0] {
      owner_none  = 2'd0,
      owner_fetch = 2'd1,
      owner_data  = 2'd2
   } tcm_owner_e;

   // Per-slave owners plus the fetch stall flag
   typedef struct packed {
      tcm_owner_e code;
      tcm_owner_e data;
      tcm_owner_e periph;
      logic       fetch_stall;
   } tcm_grant_t;

   // Master request, fetch port ties wdata and bytesel to zero
   typedef struct packed {
      logic [31:0]                  addr;
      logic [`TCM_DATA_WIDTH-1:0]   wdata;
      logic [`TCM_STRB_WIDTH-1:0]   bytesel;
      logic                         req;
   } tcm_mst_req_t;

   // Slave request after truncation to the TCM address range
   typedef struct packed {
      logic [`TCM_ADDR_WIDTH-1:0]   addr;
      logic [`TCM_DATA_WIDTH-1:0]   din;
      logic [`TCM_STRB_WIDTH-1:0]   bytesel;
      logic                         en;
   } tcm_slv_req_t;

   // Slave response, dout valid the cycle after the enable
   typedef struct packed {
      logic [`TCM_DATA_WIDTH-1:0]   dout;
      logic                         ready_nxt;
   } tcm_slv_rsp_t;

   // Master response with early and registered ready
   typedef struct packed {
      logic [`TCM_DATA_WIDTH-1:0]   rdata;
      logic                         early_ready;
      logic                         ready_r;
   } tcm_mst_rsp_t;

endpackage

// File: hw/tcm_grant.sv
// Region decode of both masters and data-first ownership of the three slaves
`include "tcm_arbiter_params.svh"

module tcm_grant (
   input  tcm_arbiter_pkg::tcm_mst_req_t fetch_req,
   input  tcm_arbiter_pkg::tcm_mst_req_t data_req,
   output tcm_arbiter_pkg::tcm_grant_t   grant
);

   // Mark one slave as owned by one master
   function automatic tcm_arbiter_pkg::tcm_grant_t claim(
      input tcm_arbiter_pkg::tcm_grant_t g,
      input tcm_arbiter_pkg::tcm_slave_e target,
      input tcm_arbiter_pkg::tcm_owner_e who
   );
      tcm_arbiter_pkg::tcm_grant_t r;
      r = g;
      case (target)
         tcm_arbiter_pkg::slave_code:   r.code   = who;
         tcm_arbiter_pkg::slave_data:   r.data   = who;
         default:                       r.periph = who;
      endcase
      return r;
   endfunction

   logic [3:0]                  fetch_region;
   logic [3:0]                  data_region;
   tcm_arbiter_pkg::tcm_slave_e fetch_target;
   tcm_arbiter_pkg::tcm_slave_e data_target;
   logic                        conflict;

   assign fetch_region = fetch_req.addr[`TCM_REGION_LSB +: 4];
   assign data_region  = data_req.addr[`TCM_REGION_LSB +: 4];

   // Data port, unmapped space lands on the peripheral bus
   always_comb begin
      case (data_region)
         `TCM_REGION_CODE:   data_target = tcm_arbiter_pkg::slave_code;
         `TCM_REGION_DATA:   data_target = tcm_arbiter_pkg::slave_data;
         `TCM_REGION_PERIPH: data_target = tcm_arbiter_pkg::slave_periph;
         default:            data_target = tcm_arbiter_pkg::slave_periph;
      endcase
   end

   // Fetch never reaches peripherals
   // Anything except data TCM falls through to code TCM
   always_comb begin
      case (fetch_region)
         `TCM_REGION_DATA: fetch_target = tcm_arbiter_pkg::slave_data;
         default:          fetch_target = tcm_arbiter_pkg::slave_code;
      endcase
   end

   // Both ports want the same slave
   assign conflict = fetch_req.req & data_req.req & (fetch_target == data_target);

   always_comb begin
      grant.code        = tcm_arbiter_pkg::owner_none;
      grant.data        = tcm_arbiter_pkg::owner_none;
      grant.periph      = tcm_arbiter_pkg::owner_none;
      grant.fetch_stall = conflict;
      // Data port always wins a shared slave
      if (data_req.req) begin
         grant = claim(grant, data_target, tcm_arbiter_pkg::owner_data);
      end
      // Losing fetch is held off this cycle
      if (fetch_req.req && !conflict) begin
         grant = claim(grant, fetch_target, tcm_arbiter_pkg::owner_fetch);
      end
   end

endmodule

// File: hw/tcm_req_route.sv
// Slave request steering and per-master early ready selection
`include "tcm_arbiter_params.svh"

module tcm_req_route (
   input  tcm_arbiter_pkg::tcm_grant_t   grant,
   input  tcm_arbiter_pkg::tcm_mst_req_t fetch_req,
   input  tcm_arbiter_pkg::tcm_mst_req_t data_req,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t code_rsp,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t data_tcm_rsp,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t periph_rsp,
   output tcm_arbiter_pkg::tcm_slv_req_t code_req,
   output tcm_arbiter_pkg::tcm_slv_req_t data_tcm_req,
   output tcm_arbiter_pkg::tcm_slv_req_t periph_req,
   output logic                          fetch_early_ready,
   output logic                          data_early_ready
);

   // Request seen by one slave given its owner
   function automatic tcm_arbiter_pkg::tcm_slv_req_t route_one(
      input tcm_arbiter_pkg::tcm_owner_e   owner,
      input tcm_arbiter_pkg::tcm_mst_req_t f,
      input tcm_arbiter_pkg::tcm_mst_req_t d
   );
      tcm_arbiter_pkg::tcm_slv_req_t r;
      tcm_arbiter_pkg::tcm_mst_req_t src;
      // Unowned slave sees an idle, all-zero bus
      r   = '0;
      src = (owner == tcm_arbiter_pkg::owner_data) ? d : f;
      if (owner != tcm_arbiter_pkg::owner_none) begin
         // Only the low address bits reach the TCM
         r.addr    = src.addr[`TCM_ADDR_WIDTH-1:0];
         r.din     = src.wdata;
         r.bytesel = src.bytesel;
         r.en      = src.req;
      end
      return r;
   endfunction

   logic fetch_on_code;
   logic fetch_on_data;
   logic data_on_code;
   logic data_on_data;
   logic data_on_periph;

   assign code_req     = route_one(grant.code, fetch_req, data_req);
   assign data_tcm_req = route_one(grant.data, fetch_req, data_req);
   assign periph_req   = route_one(grant.periph, fetch_req, data_req);

   // Ownership flags per master and slave
   assign fetch_on_code  = (grant.code == tcm_arbiter_pkg::owner_fetch);
   assign fetch_on_data  = (grant.data == tcm_arbiter_pkg::owner_fetch);
   assign data_on_code   = (grant.code == tcm_arbiter_pkg::owner_data);
   assign data_on_data   = (grant.data == tcm_arbiter_pkg::owner_data);
   assign data_on_periph = (grant.periph == tcm_arbiter_pkg::owner_data);

   // Stalled fetch owns nothing, so its early ready stays low
   assign fetch_early_ready = (fetch_on_code & code_rsp.ready_nxt) |
                              (fetch_on_data & data_tcm_rsp.ready_nxt);

   // Data port follows whichever slave it holds
   assign data_early_ready = (data_on_code & code_rsp.ready_nxt) |
                             (data_on_data & data_tcm_rsp.ready_nxt) |
                             (data_on_periph & periph_rsp.ready_nxt);

endmodule

// File: hw/tcm_resp_return.sv
// Registered return source and ready per master with read data mux
`include "tcm_arbiter_params.svh"

module tcm_resp_return (
   input  logic                          clk,
   input  logic                          rst_n,
   input  tcm_arbiter_pkg::tcm_grant_t   grant,
   input  logic                          fetch_early_ready,
   input  logic                          data_early_ready,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t code_rsp,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t data_tcm_rsp,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t periph_rsp,
   output tcm_arbiter_pkg::tcm_mst_rsp_t fetch_rsp,
   output tcm_arbiter_pkg::tcm_mst_rsp_t data_rsp
);

   // Slave held by a master, native slave when idle or stalled
   function automatic tcm_arbiter_pkg::tcm_slave_e source_of(
      input tcm_arbiter_pkg::tcm_grant_t g,
      input tcm_arbiter_pkg::tcm_owner_e who,
      input tcm_arbiter_pkg::tcm_slave_e native
   );
      if (g.code == who) begin
         return tcm_arbiter_pkg::slave_code;
      end else if (g.data == who) begin
         return tcm_arbiter_pkg::slave_data;
      end else if (g.periph == who) begin
         return tcm_arbiter_pkg::slave_periph;
      end
      return native;
   endfunction

   // Read data of the selected slave
   function automatic logic [`TCM_DATA_WIDTH-1:0] pick_dout(
      input tcm_arbiter_pkg::tcm_slave_e   src,
      input tcm_arbiter_pkg::tcm_slv_rsp_t c,
      input tcm_arbiter_pkg::tcm_slv_rsp_t d,
      input tcm_arbiter_pkg::tcm_slv_rsp_t p
   );
      case (src)
         tcm_arbiter_pkg::slave_data:   return d.dout;
         tcm_arbiter_pkg::slave_periph: return p.dout;
         default:                       return c.dout;
      endcase
   endfunction

   tcm_arbiter_pkg::tcm_slave_e fetch_src_r;
   tcm_arbiter_pkg::tcm_slave_e data_src_r;
   logic                        fetch_ready_r;
   logic                        data_ready_r;

   // Sources sampled on the request edge, used the cycle after
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_src_r   <= tcm_arbiter_pkg::slave_code;
         data_src_r    <= tcm_arbiter_pkg::slave_data;
         fetch_ready_r <= 1'b0;
         data_ready_r  <= 1'b0;
      end else begin
         fetch_src_r   <= source_of(grant, tcm_arbiter_pkg::owner_fetch,
                                    tcm_arbiter_pkg::slave_code);
         data_src_r    <= source_of(grant, tcm_arbiter_pkg::owner_data,
                                    tcm_arbiter_pkg::slave_data);
         fetch_ready_r <= fetch_early_ready;
         data_ready_r  <= data_early_ready;
      end
   end

   always_comb begin
      fetch_rsp.rdata       = pick_dout(fetch_src_r, code_rsp, data_tcm_rsp, periph_rsp);
      fetch_rsp.early_ready = fetch_early_ready;
      fetch_rsp.ready_r     = fetch_ready_r;
      data_rsp.rdata        = pick_dout(data_src_r, code_rsp, data_tcm_rsp, periph_rsp);
      data_rsp.early_ready  = data_early_ready;
      data_rsp.ready_r      = data_ready_r;
   end

endmodule

// File: hw/tcm_arbiter.sv
// Top level of the TCM crossbar with grant, request route and response return
module tcm_arbiter (
   input  logic                          clk,
   input  logic                          rst_n,
   // Master ports
   input  tcm_arbiter_pkg::tcm_mst_req_t fetch_req,
   input  tcm_arbiter_pkg::tcm_mst_req_t data_req,
   output tcm_arbiter_pkg::tcm_mst_rsp_t fetch_rsp,
   output tcm_arbiter_pkg::tcm_mst_rsp_t data_rsp,
   // Slave ports
   output tcm_arbiter_pkg::tcm_slv_req_t code_req,
   output tcm_arbiter_pkg::tcm_slv_req_t data_tcm_req,
   output tcm_arbiter_pkg::tcm_slv_req_t periph_req,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t code_rsp,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t data_tcm_rsp,
   input  tcm_arbiter_pkg::tcm_slv_rsp_t periph_rsp
);

   tcm_arbiter_pkg::tcm_grant_t grant;
   logic                        fetch_early_ready;
   logic                        data_early_ready;

   // Decode and priority
   tcm_grant u_grant (
      .fetch_req (fetch_req),
      .data_req  (data_req),
      .grant     (grant)
   );

   // Slave buses and early readies
   tcm_req_route u_route (
      .grant             (grant),
      .fetch_req         (fetch_req),
      .data_req          (data_req),
      .code_rsp          (code_rsp),
      .data_tcm_rsp      (data_tcm_rsp),
      .periph_rsp        (periph_rsp),
      .code_req          (code_req),
      .data_tcm_req      (data_tcm_req),
      .periph_req        (periph_req),
      .fetch_early_ready (fetch_early_ready),
      .data_early_ready  (data_early_ready)
   );

   // Registered return path
   tcm_resp_return u_return (
      .clk               (clk),
      .rst_n             (rst_n),
      .grant             (grant),
      .fetch_early_ready (fetch_early_ready),
      .data_early_ready  (data_early_ready),
      .code_rsp          (code_rsp),
      .data_tcm_rsp      (data_tcm_rsp),
      .periph_rsp        (periph_rsp),
      .fetch_rsp         (fetch_rsp),
      .data_rsp          (data_rsp)
   );

endmodule

// File: test/tcm_arbiter_tb.sv
// Table-driven testbench for the TCM crossbar arbiter with a reference model and a watchdog
`include "tcm_arbiter_params.svh"

module tcm_arbiter_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 4;
   localparam int NUM_ROWS   = 15;

   // One table row: both master requests, slave readies and read data
   typedef struct packed {
      tcm_arbiter_pkg::tcm_mst_req_t          fetch;
      tcm_arbiter_pkg::tcm_mst_req_t          data;
      logic [2:0]                             rdy;
      logic [2:0][`TCM_DATA_WIDTH-1:0]        dout;
   } stim_row_t;

   logic                          clk;
   logic                          rst_n;
   tcm_arbiter_pkg::tcm_mst_req_t fetch_req;
   tcm_arbiter_pkg::tcm_mst_req_t data_req;
   tcm_arbiter_pkg::tcm_mst_rsp_t fetch_rsp;
   tcm_arbiter_pkg::tcm_mst_rsp_t data_rsp;
   tcm_arbiter_pkg::tcm_slv_req_t code_req;
   tcm_arbiter_pkg::tcm_slv_req_t data_tcm_req;
   tcm_arbiter_pkg::tcm_slv_req_t periph_req;
   tcm_arbiter_pkg::tcm_slv_rsp_t code_rsp;
   tcm_arbiter_pkg::tcm_slv_rsp_t data_tcm_rsp;
   tcm_arbiter_pkg::tcm_slv_rsp_t periph_rsp;

   stim_row_t                     stim_table [NUM_ROWS];
   stim_row_t                     row;
   tcm_arbiter_pkg::tcm_slv_req_t exp_slv [3];
   // Model state carried across the rising edge
   int                            prev_fetch_src;
   int                            prev_data_src;
   logic                          prev_fetch_er;
   logic                          prev_data_er;
   int                            f_tgt;
   int                            d_tgt;
   logic                          f_own;
   logic                          d_own;
   logic                          exp_f_er;
   logic                          exp_d_er;
   int                            i;

   tcm_arbiter u_tcm_arbiter (
      .clk          (clk),
      .rst_n        (rst_n),
      .fetch_req    (fetch_req),
      .data_req     (data_req),
      .fetch_rsp    (fetch_rsp),
      .data_rsp     (data_rsp),
      .code_req     (code_req),
      .data_tcm_req (data_tcm_req),
      .periph_req   (periph_req),
      .code_rsp     (code_rsp),
      .data_tcm_rsp (data_tcm_rsp),
      .periph_rsp   (periph_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Run limit sized from the table length
   initial begin
      #((NUM_ROWS + 10) * CLK_PERIOD);
      $display("Timeout: the table did not finish in the expected time");
      $display("Verification failed");
      $fatal(1, "Watchdog expired");
   end

   // Slave index 0 code TCM, 1 data TCM, 2 peripheral bus
   function automatic int data_target(input logic [31:0] addr);
      logic [3:0] nib;
      nib = addr[`TCM_REGION_LSB +: 4];
      if (nib == `TCM_REGION_CODE) return 0;
      if (nib == `TCM_REGION_DATA) return 1;
      return 2;
   endfunction

   // Fetch only reaches data TCM, everything else lands on code TCM
   function automatic int fetch_target(input logic [31:0] addr);
      if (addr[`TCM_REGION_LSB +: 4] == `TCM_REGION_DATA) return 1;
      return 0;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
         $display("Verification failed");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   // rdy bits ordered periph, data, code
   task automatic set_row(input int idx, input logic [31:0] f_addr, input logic f_req,
                          input logic [31:0] d_addr, input logic [31:0] d_wdata,
                          input logic [3:0] d_sel, input logic d_req, input logic [2:0] rdy,
                          input logic [31:0] c_dout, input logic [31:0] t_dout,
                          input logic [31:0] p_dout);
      stim_table[idx].fetch   = '{addr: f_addr, wdata: '0, bytesel: '0, req: f_req};
      stim_table[idx].data    = '{addr: d_addr, wdata: d_wdata, bytesel: d_sel, req: d_req};
      stim_table[idx].rdy     = rdy;
      stim_table[idx].dout[0] = c_dout;
      stim_table[idx].dout[1] = t_dout;
      stim_table[idx].dout[2] = p_dout;
   endtask

   task automatic load_table();
      // No conflict
      set_row(0, 32'h0000_0104, 1, 32'h2000_0208, 32'haaaa_0001, 4'hf, 1, 3'b111,
              32'hc0de_0000, 32'hda7a_0000, 32'h9e41_0000);
      // Both on data TCM
      set_row(1, 32'h2000_0010, 1, 32'h2000_0abc, 32'h1234_5678, 4'h3, 1, 3'b111,
              32'hc0de_0001, 32'hda7a_0001, 32'h9e41_0001);
      // Cross access
      set_row(2, 32'h2000_0020, 1, 32'h0000_0344, 32'h0, 4'h0, 1, 3'b111,
              32'hc0de_0002, 32'hda7a_0002, 32'h9e41_0002);
      // Peripheral data, fetch from region F
      set_row(3, 32'hf000_0040, 1, 32'hf000_0010, 32'hcafe_f00d, 4'hc, 1, 3'b111,
              32'hc0de_0003, 32'hda7a_0003, 32'h9e41_0003);
      // Unmapped data region
      set_row(4, 32'h0000_0080, 1, 32'h5000_0ffc, 32'h0bad_beef, 4'h1, 1, 3'b111,
              32'hc0de_0004, 32'hda7a_0004, 32'h9e41_0004);
      set_row(5, 32'h0, 0, 32'h0, 32'h0, 4'h0, 0, 3'b111,
              32'hc0de_0005, 32'hda7a_0005, 32'h9e41_0005);
      // Code TCM holds off the fetch for two rows
      set_row(6, 32'h0000_0100, 1, 32'h2000_0100, 32'h0, 4'h0, 1, 3'b110,
              32'hc0de_0006, 32'hda7a_0006, 32'h9e41_0006);
      set_row(7, 32'h0000_0100, 1, 32'h2000_0100, 32'h0, 4'h0, 1, 3'b110,
              32'hc0de_0007, 32'hda7a_0007, 32'h9e41_0007);
      set_row(8, 32'h0000_0100, 1, 32'h2000_0100, 32'h0, 4'h0, 1, 3'b111,
              32'hc0de_0008, 32'hda7a_0008, 32'h9e41_0008);
      set_row(9, 32'h0, 0, 32'h0, 32'h0, 4'h0, 0, 3'b111,
              32'hc0de_0009, 32'hda7a_0009, 32'h9e41_0009);
      // Peripheral stall on the data port
      set_row(10, 32'h0, 0, 32'hf000_0020, 32'h5555_aaaa, 4'hf, 1, 3'b011,
              32'hc0de_000a, 32'hda7a_000a, 32'h9e41_000a);
      set_row(11, 32'h0, 0, 32'hf000_0020, 32'h5555_aaaa, 4'hf, 1, 3'b111,
              32'hc0de_000b, 32'hda7a_000b, 32'h9e41_000b);
      // Lone fetch to data TCM, then to an unmapped region
      set_row(12, 32'h2000_0300, 1, 32'h0, 32'h0, 4'h0, 0, 3'b111,
              32'hc0de_000c, 32'hda7a_000c, 32'h9e41_000c);
      set_row(13, 32'h3000_0200, 1, 32'h0, 32'h0, 4'h0, 0, 3'b111,
              32'hc0de_000d, 32'hda7a_000d, 32'h9e41_000d);
      set_row(14, 32'h0, 0, 32'h0, 32'h0, 4'h0, 0, 3'b111,
              32'hc0de_000e, 32'hda7a_000e, 32'h9e41_000e);
   endtask

   initial begin
      rst_n        = 1'b0;
      fetch_req    = '0;
      data_req     = '0;
      code_rsp     = '0;
      data_tcm_rsp = '0;
      periph_rsp   = '0;
      // Native return sources and idle readies out of reset
      prev_fetch_src = 0;
      prev_data_src  = 1;
      prev_fetch_er  = 1'b0;
      prev_data_er   = 1'b0;
      load_table();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (i = 0; i < NUM_ROWS; i++) begin
         row                    = stim_table[i];
         fetch_req              = row.fetch;
         data_req               = row.data;
         code_rsp.ready_nxt     = row.rdy[0];
         code_rsp.dout          = row.dout[0];
         data_tcm_rsp.ready_nxt = row.rdy[1];
         data_tcm_rsp.dout      = row.dout[1];
         periph_rsp.ready_nxt   = row.rdy[2];
         periph_rsp.dout        = row.dout[2];
         #1;
         // Data first, fetch only when the slave is free
         d_tgt = data_target(row.data.addr);
         f_tgt = fetch_target(row.fetch.addr);
         d_own = row.data.req;
         f_own = row.fetch.req && !(d_own && (f_tgt == d_tgt));
         for (int s = 0; s < 3; s++) begin
            exp_slv[s] = '0;
            if (d_own && (d_tgt == s)) begin
               exp_slv[s].addr    = row.data.addr[`TCM_ADDR_WIDTH-1:0];
               exp_slv[s].din     = row.data.wdata;
               exp_slv[s].bytesel = row.data.bytesel;
               exp_slv[s].en      = 1'b1;
            end else if (f_own && (f_tgt == s)) begin
               exp_slv[s].addr    = row.fetch.addr[`TCM_ADDR_WIDTH-1:0];
               exp_slv[s].en      = 1'b1;
            end
         end
         exp_f_er = f_own && row.rdy[f_tgt];
         exp_d_er = d_own && row.rdy[d_tgt];
         check_value($sformatf("row %0d code_req", i), code_req, exp_slv[0]);
         check_value($sformatf("row %0d data_tcm_req", i), data_tcm_req, exp_slv[1]);
         check_value($sformatf("row %0d periph_req", i), periph_req, exp_slv[2]);
         check_value($sformatf("row %0d fetch early_ready", i), fetch_rsp.early_ready, exp_f_er);
         check_value($sformatf("row %0d data early_ready", i), data_rsp.early_ready, exp_d_er);
         check_value($sformatf("row %0d fetch rdata", i), fetch_rsp.rdata,
                     row.dout[prev_fetch_src]);
         check_value($sformatf("row %0d data rdata", i), data_rsp.rdata,
                     row.dout[prev_data_src]);
         check_value($sformatf("row %0d fetch ready_r", i), fetch_rsp.ready_r, prev_fetch_er);
         check_value($sformatf("row %0d data ready_r", i), data_rsp.ready_r, prev_data_er);
         // State the DUT registers at the coming edge
         prev_fetch_src = f_own ? f_tgt : 0;
         prev_data_src  = d_own ? d_tgt : 1;
         prev_fetch_er  = exp_f_er;
         prev_data_er   = exp_d_er;
         @(negedge clk);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

// File: tcm_arbiter.f
+incdir+include
hw/tcm_arbiter_pkg.sv
hw/tcm_grant.sv
hw/tcm_req_route.sv
hw/tcm_resp_return.sv
hw/tcm_arbiter.sv
test/tcm_arbiter_tb.sv

// File: Bender.yml
package:
  name: tcm_arbiter

sources:
  - include_dirs:
      - include
    files:
      - hw/tcm_arbiter_pkg.sv
      - hw/tcm_grant.sv
      - hw/tcm_req_route.sv
      - hw/tcm_resp_return.sv
      - hw/tcm_arbiter.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tcm_arbiter_tb.sv
